/* Makefile */
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
RTL_TOP   ?= riscv_core
FLIST     ?= riscv_core.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/riscv_core_tb.sv */
`timescale 1ns/1ns

module riscv_core_tb;
    import core_pkg::*;

    localparam logic [31:0] SEED     = 32'hce0c_7a93;
    localparam logic [31:0] NOP      = 32'h0000_0013;
    localparam int          TIMEOUT  = 200;
    localparam logic [6:0]  OP_R     = 7'h33;
    localparam logic [6:0]  OP_I     = 7'h13;
    localparam logic [6:0]  OP_LUI_C = 7'h37;
    localparam logic [6:0]  OP_AUI_C = 7'h17;

    logic        clk;
    logic        rstn;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] img_idx;
    retire_t     retire;

    logic [31:0] image [128];
    int          prog_len;
    int          a_end, b_end, c_end, d_end;

    // Reference model state
    logic [31:0] mregs [32];
    logic [31:0] mmem [256];
    logic [31:0] model_pc;
    int          n_retired;
    int          cyc;
    int          last_cyc;
    logic        last_in_a;

    int          errors;
    int          checks;
    int          tests;

    riscv_core dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .retire_o    (retire)
    );

    always #4 clk = ~clk;

    // Same-cycle instruction memory
    always_comb begin
        img_idx   = (imem_addr - RESET_PC) >> 2;
        imem_data = (img_idx < 32'(prog_len)) ? image[img_idx[6:0]] : NOP;
    end

    function automatic logic [31:0] img_word(input logic [31:0] addr);
        logic [31:0] i;
        i = (addr - RESET_PC) >> 2;
        return (i < 32'(prog_len)) ? image[i[6:0]] : NOP;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // ISA arithmetic for OP and OP-IMM
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic is_reg, input logic [31:0] x,
                                            input logic [31:0] y);
        case (f3)
            3'd0:    return (alt && is_reg) ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        image[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_alu_block();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        prev_rd = 5'd1;
        for (int k = 0; k < 24; k++) begin
            kind = $urandom % 4;
            rd   = 5'($urandom % 8);
            rs1  = ($urandom % 2 == 0) ? prev_rd : 5'($urandom % 8);
            rs2  = 5'($urandom % 8);
            f3   = 3'($urandom % 8);
            alt  = 1'($urandom % 2);
            imm  = 12'($urandom);
            case (kind)
                0: emit(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd, OP_R));
                1: begin
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    else if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                    emit(enc_i(imm, rs1, f3, rd, OP_I));
                end
                2: emit({20'($urandom), rd, OP_LUI_C});
                default: emit({20'($urandom), rd, OP_AUI_C});
            endcase
            prev_rd = rd;
        end
        // x0 stays zero after a write
        emit(enc_i(12'h123, 5'd0, 3'd0, 5'd0, OP_I));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9, OP_R));
        a_end = prog_len;
    endtask

    task automatic build_mem_block();
        emit(enc_i(12'h100, 5'd0, 3'd0, 5'd10, OP_I));
        emit({20'h12345, 5'd12, OP_LUI_C});
        emit(enc_i(12'h678, 5'd12, 3'd0, 5'd12, OP_I));
        emit(enc_s(12'd8, 5'd12, 5'd10));
        emit(enc_i(12'd8, 5'd10, 3'b010, 5'd13, 7'h03));
        emit(enc_r(7'h00, 5'd13, 5'd13, 3'd0, 5'd14, OP_R));
        emit(enc_s(12'd12, 5'd14, 5'd10));
        emit(enc_i(12'd12, 5'd10, 3'b010, 5'd15, 7'h03));
        emit(enc_r(7'h20, 5'd13, 5'd15, 3'd0, 5'd16, OP_R));
        b_end = prog_len;
    endtask

    // Taken branch skips one marker write, the untaken one falls into it
    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1,
                               input logic [4:0] t2, input logic [4:0] n1,
                               input logic [4:0] n2);
        emit(enc_b(13'd8, t2, t1, f3));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd20, OP_I));
        emit(enc_b(13'd8, n2, n1, f3));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd21, OP_I));
    endtask

    task automatic build_branch_block();
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, OP_I));
        emit(enc_i(12'hffd, 5'd0, 3'd0, 5'd2, OP_I));
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd3, OP_I));
        branch_pair(3'd0, 5'd1, 5'd3, 5'd1, 5'd2);
        branch_pair(3'd1, 5'd1, 5'd2, 5'd1, 5'd3);
        branch_pair(3'd4, 5'd2, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd5, 5'd1, 5'd2, 5'd2, 5'd1);
        branch_pair(3'd6, 5'd1, 5'd2, 5'd2, 5'd1);
        branch_pair(3'd7, 5'd2, 5'd1, 5'd1, 5'd2);
        c_end = prog_len;
    endtask

    task automatic build_jump_block();
        emit(enc_j(21'd12, 5'd5));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd22, OP_I));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd22, OP_I));
        emit({20'h0, 5'd6, OP_AUI_C});
        // Odd offset, bit 0 of the target is dropped
        emit(enc_i(12'd17, 5'd6, 3'd0, 5'd7, 7'h67));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd23, OP_I));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd23, OP_I));
        emit(enc_r(7'h00, 5'd7, 5'd5, 3'd0, 5'd8, OP_R));
        d_end = prog_len;
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("error %s expected %08h actual %08h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic in_block_a(input logic [31:0] pc);
        return pc >= RESET_PC && pc < RESET_PC + 32'(a_end * 4);
    endfunction

    always @(posedge clk) begin : model_check
        logic [31:0] ins, a, b, val, npc, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic        wr, st, take;
        logic [4:0]  rd;
        cyc++;
        if (!rstn) begin
            compare_word("retire_o.valid", 32'd0, {31'b0, retire.valid});
        end else if (retire.valid) begin
            ins   = img_word(model_pc);
            rd    = ins[11:7];
            a     = mregs[ins[19:15]];
            b     = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            npc   = model_pc + 32'd4;
            wr    = 1'b1;
            st    = 1'b0;
            take  = 1'b0;
            val   = '0;
            addr  = a + imm_i;
            case (ins[6:0])
                7'h37: val = {ins[31:12], 12'b0};
                7'h17: val = model_pc + {ins[31:12], 12'b0};
                7'h6f: begin
                    val = model_pc + 32'd4;
                    npc = model_pc + imm_j;
                end
                7'h67: begin
                    val = model_pc + 32'd4;
                    npc = addr & ~32'd1;
                end
                7'h63: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'd0:    take = a == b;
                        3'd1:    take = a != b;
                        3'd4:    take = $signed(a) < $signed(b);
                        3'd5:    take = $signed(a) >= $signed(b);
                        3'd6:    take = a < b;
                        default: take = a >= b;
                    endcase
                    if (take) npc = model_pc + imm_b;
                end
                7'h03: val = mmem[addr[9:2]];
                7'h23: begin
                    wr   = 1'b0;
                    st   = 1'b1;
                    addr = a + imm_s;
                end
                7'h13: val = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
                default: val = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
            endcase
            compare_word("retire_o.pc", model_pc, retire.pc);
            compare_word("retire_o.instr", ins, retire.instr);
            compare_word("retire_o.reg_we", {31'b0, wr}, {31'b0, retire.reg_we});
            compare_word("retire_o.mem_we", {31'b0, st}, {31'b0, retire.mem_we});
            if (wr) begin
                compare_word("retire_o.rd", {27'b0, rd}, {27'b0, retire.rd});
            end
            if (wr && rd != 5'd0) begin
                compare_word("retire_o.rd_data", val, retire.rd_data);
                mregs[rd] = val;
            end
            if (st) begin
                compare_word("retire_o.mem_addr", addr, retire.mem_addr);
                compare_word("retire_o.mem_wdata", b, retire.mem_wdata);
                mmem[addr[9:2]] = b;
            end
            // Hazard-free block retires one per cycle
            if (in_block_a(model_pc) && last_in_a) begin
                checks++;
                assert (cyc == last_cyc + 1) else begin
                    $display("retirement at pc %08h came %0d cycles after the previous one",
                             model_pc, cyc - last_cyc);
                    errors++;
                end
            end
            last_in_a = in_block_a(model_pc);
            last_cyc  = cyc;
            model_pc  = npc;
            n_retired++;
        end
    end

    task automatic wait_past(input string what, input int end_idx);
        int n;
        n = 0;
        while (model_pc < RESET_PC + 32'(end_idx * 4) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("timeout: the %s block did not finish retiring", what);
            errors++;
        end
    endtask

    task automatic wait_first_retire();
        int n;
        n = 0;
        while (n_retired == 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("timeout: no instruction retired after reset");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s done, %0d mismatches", name, errors - err_before);
    endtask

    initial begin
        int e0;
        clk       = 1'b0;
        rstn      = 1'b0;
        prog_len  = 0;
        model_pc  = RESET_PC;
        n_retired = 0;
        cyc       = 0;
        last_cyc  = 0;
        last_in_a = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        for (int i = 0; i < 128; i++) image[i] = NOP;
        void'($urandom(SEED));
        build_alu_block();
        build_mem_block();
        build_branch_block();
        build_jump_block();

        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        e0 = errors;
        wait_first_retire();
        report_test("reset", e0);
        e0 = errors;
        wait_past("random ALU", a_end);
        report_test("alu_random", e0);
        e0 = errors;
        wait_past("load/store", b_end);
        report_test("load_store", e0);
        e0 = errors;
        wait_past("branch", c_end);
        report_test("branches", e0);
        e0 = errors;
        wait_past("jump", d_end);
        report_test("jumps", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* logic/core_pkg.sv */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // funct7 value that selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // OP_NONE stays first so an all-zero register is a bubble
    typedef enum logic [4:0] {
        OP_NONE,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LW, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        op_e                   op;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic                  reg_we;
        logic                  mem_re;
        logic                  mem_we;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       mem_addr;
        logic [XLEN-1:0]       store_data;
        logic                  reg_we;
        logic                  mem_re;
        logic                  mem_we;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rd_data;
        logic                  reg_we;
        logic                  mem_we;
        logic [XLEN-1:0]       mem_addr;
        logic [XLEN-1:0]       mem_wdata;
    } retire_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic stall_fetch;
        logic flush_if_id;
        logic flush_id_ex;
    } hazard_ctrl_t;

endpackage

/* logic/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                            clk,
    input  logic                            rstn,
    input  core_pkg::if_id_t                if_id_i,
    input  core_pkg::retire_t               wb_i,
    input  logic                            flush_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output core_pkg::id_ex_t                id_ex_o
);
    import core_pkg::*;

    logic [XLEN-1:0] instr;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    op_e             op;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    id_ex_t          id_ex_d;

    assign instr  = if_id_i.instr;
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    // Writeback of the same cycle is visible to decode
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
        if (wb_i.valid && wb_i.reg_we && wb_i.rd != '0 && wb_i.rd == idx) begin
            return wb_i.rd_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        op  = OP_NONE;
        imm = {{20{instr[31]}}, instr[31:20]};
        case (instr[6:0])
            OPC_LUI: begin
                op  = OP_LUI;
                imm = {instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                op  = OP_AUIPC;
                imm = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) op = OP_JALR;
            end
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) op = OP_LW;
            end
            OPC_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == 3'b010) op = OP_SW;
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    3'b001: begin
                        if (funct7 == 7'b0) op = OP_SLLI;
                    end
                    default: begin
                        if (funct7 == 7'b0) op = OP_SRLI;
                        else if (funct7 == F7_ALT) op = OP_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b001:  op = OP_SLL;
                        3'b010:  op = OP_SLT;
                        3'b011:  op = OP_SLTU;
                        3'b100:  op = OP_XOR;
                        3'b101:  op = OP_SRL;
                        3'b110:  op = OP_OR;
                        default: op = OP_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == 3'b000) op = OP_SUB;
                    else if (funct3 == 3'b101) op = OP_SRA;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        id_ex_d.valid    = if_id_i.valid;
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.instr    = instr;
        id_ex_d.op       = op;
        id_ex_d.imm      = imm;
        id_ex_d.rd       = instr[11:7];
        id_ex_d.rs1      = rs1_o;
        id_ex_d.rs2      = rs2_o;
        id_ex_d.rs1_data = read_reg(rs1_o);
        id_ex_d.rs2_data = read_reg(rs2_o);
        // Branches, stores and unknown encodings leave rd alone
        id_ex_d.reg_we   = if_id_i.valid && !(op inside {OP_NONE, OP_SW, OP_BEQ, OP_BNE,
                                                         OP_BLT, OP_BGE, OP_BLTU, OP_BGEU});
        id_ex_d.mem_re   = if_id_i.valid && op == OP_LW;
        id_ex_d.mem_we   = if_id_i.valid && op == OP_SW;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.reg_we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.rd_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_ex_o <= '0;
        end else if (flush_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_pkg::id_ex_t          id_ex_i,
    input  core_pkg::fwd_e            fwd_rs1_i,
    input  core_pkg::fwd_e            fwd_rs2_i,
    input  logic [core_pkg::XLEN-1:0] mem_fwd_i,
    input  logic [core_pkg::XLEN-1:0] wb_fwd_i,
    output core_pkg::redirect_t       redirect_o,
    output core_pkg::ex_mem_t         ex_mem_o
);
    import core_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] result;
    logic            taken;

    function automatic logic [XLEN-1:0] operand(input fwd_e sel, input logic [XLEN-1:0] val);
        case (sel)
            FWD_MEM: return mem_fwd_i;
            FWD_WB:  return wb_fwd_i;
            default: return val;
        endcase
    endfunction

    assign a    = operand(fwd_rs1_i, id_ex_i.rs1_data);
    assign b    = operand(fwd_rs2_i, id_ex_i.rs2_data);
    assign imm  = id_ex_i.imm;
    // Load/store address and JALR target share this adder
    assign sum  = a + imm;
    assign link = id_ex_i.pc + 32'd4;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (id_ex_i.op)
            OP_LUI:   result = imm;
            OP_AUIPC: result = id_ex_i.pc + imm;
            OP_JAL,
            OP_JALR: begin
                result = link;
                taken  = 1'b1;
            end
            OP_BEQ:   taken = (a == b);
            OP_BNE:   taken = (a != b);
            OP_BLT:   taken = ($signed(a) < $signed(b));
            OP_BGE:   taken = ($signed(a) >= $signed(b));
            OP_BLTU:  taken = (a < b);
            OP_BGEU:  taken = (a >= b);
            OP_ADDI:  result = sum;
            OP_SLTI:  result = XLEN'($signed(a) < $signed(imm));
            OP_SLTIU: result = XLEN'(a < imm);
            OP_XORI:  result = a ^ imm;
            OP_ORI:   result = a | imm;
            OP_ANDI:  result = a & imm;
            OP_SLLI:  result = a << imm[4:0];
            OP_SRLI:  result = a >> imm[4:0];
            OP_SRAI:  result = $signed(a) >>> imm[4:0];
            OP_ADD:   result = a + b;
            OP_SUB:   result = a - b;
            OP_SLL:   result = a << b[4:0];
            OP_SLT:   result = XLEN'($signed(a) < $signed(b));
            OP_SLTU:  result = XLEN'(a < b);
            OP_XOR:   result = a ^ b;
            OP_SRL:   result = a >> b[4:0];
            OP_SRA:   result = $signed(a) >>> b[4:0];
            OP_OR:    result = a | b;
            OP_AND:   result = a & b;
            default: ;
        endcase
    end

    assign redirect_o.taken  = id_ex_i.valid && taken;
    assign redirect_o.target = (id_ex_i.op == OP_JALR) ? {sum[XLEN-1:1], 1'b0}
                                                        : id_ex_i.pc + imm;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.instr      <= id_ex_i.instr;
            ex_mem_o.op         <= id_ex_i.op;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.result     <= result;
            ex_mem_o.mem_addr   <= sum;
            ex_mem_o.store_data <= b;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
            ex_mem_o.mem_re     <= id_ex_i.mem_re;
            ex_mem_o.mem_we     <= id_ex_i.mem_we;
        end
    end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                       clk,
    input  logic                       rstn,
    input  core_pkg::hazard_ctrl_t     ctrl_i,
    input  logic [core_pkg::XLEN-1:0]  redirect_pc_i,
    output logic [core_pkg::XLEN-1:0]  imem_addr_o,
    input  logic [core_pkg::XLEN-1:0]  imem_data_i,
    output core_pkg::if_id_t           if_id_o
);
    import core_pkg::*;

    logic [XLEN-1:0] pc;

    assign imem_addr_o = pc;

    // A redirect always wins over a load-use hold
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (ctrl_i.flush_if_id) begin
            pc <= redirect_pc_i;
        end else if (!ctrl_i.stall_fetch) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            if_id_o <= '0;
        end else if (ctrl_i.flush_if_id) begin
            if_id_o <= '0;
        end else if (!ctrl_i.stall_fetch) begin
            if_id_o.valid <= 1'b1;
            if_id_o.pc    <= pc;
            if_id_o.instr <= imem_data_i;
        end
    end

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic [core_pkg::REG_ADDR_W-1:0] id_rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] id_rs2_i,
    input  core_pkg::id_ex_t                id_ex_i,
    input  core_pkg::ex_mem_t               ex_mem_i,
    input  core_pkg::retire_t               mem_wb_i,
    input  core_pkg::redirect_t             redirect_i,
    output core_pkg::hazard_ctrl_t          ctrl_o,
    output core_pkg::fwd_e                  fwd_rs1_o,
    output core_pkg::fwd_e                  fwd_rs2_o
);
    import core_pkg::*;

    logic load_use;

    // Memory stage holds the younger writer, so it is checked first
    function automatic fwd_e fwd_sel(input logic [REG_ADDR_W-1:0] rs);
        if (rs == '0) begin
            return FWD_NONE;
        end else if (ex_mem_i.valid && ex_mem_i.reg_we && ex_mem_i.rd == rs) begin
            return FWD_MEM;
        end else if (mem_wb_i.valid && mem_wb_i.reg_we && mem_wb_i.rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_rs1_o = fwd_sel(id_ex_i.rs1);
    assign fwd_rs2_o = fwd_sel(id_ex_i.rs2);

    assign load_use = id_ex_i.valid && id_ex_i.mem_re && id_ex_i.rd != '0
                      && (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

    always_comb begin
        ctrl_o = '0;
        if (redirect_i.taken) begin
            ctrl_o.flush_if_id = 1'b1;
            ctrl_o.flush_id_ex = 1'b1;
        end else if (load_use) begin
            // Hold the consumer in decode and send a bubble down
            ctrl_o.stall_fetch = 1'b1;
            ctrl_o.flush_id_ex = 1'b1;
        end
    end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_pkg::ex_mem_t         ex_mem_i,
    output logic [core_pkg::XLEN-1:0] mem_fwd_o,
    output core_pkg::retire_t         mem_wb_o
);
    import core_pkg::*;

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] idx;
    logic [XLEN-1:0]       load_data;

    // Word index, byte offset ignored
    assign idx       = ex_mem_i.mem_addr[DMEM_IDX_W+1:2];
    assign load_data = dmem[idx];
    assign mem_fwd_o = (ex_mem_i.mem_re && ex_mem_i.op == OP_LW) ? load_data : ex_mem_i.result;

    always_ff @(posedge clk) begin
        if (ex_mem_i.valid && ex_mem_i.mem_we) begin
            dmem[idx] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.valid     <= ex_mem_i.valid;
            mem_wb_o.pc        <= ex_mem_i.pc;
            mem_wb_o.instr     <= ex_mem_i.instr;
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.rd_data   <= mem_fwd_o;
            mem_wb_o.reg_we    <= ex_mem_i.reg_we;
            mem_wb_o.mem_we    <= ex_mem_i.mem_we;
            mem_wb_o.mem_addr  <= ex_mem_i.mem_addr;
            mem_wb_o.mem_wdata <= ex_mem_i.store_data;
        end
    end

endmodule

/* logic/riscv_core.sv */
`timescale 1ns/1ns

module riscv_core (
    input  logic                      clk,
    input  logic                      rstn,
    output logic [core_pkg::XLEN-1:0] imem_addr_o,
    input  logic [core_pkg::XLEN-1:0] imem_data_i,
    output core_pkg::retire_t         retire_o
);
    import core_pkg::*;

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    retire_t               mem_wb;
    redirect_t             redirect;
    hazard_ctrl_t          hz_ctrl;
    fwd_e                  fwd_rs1;
    fwd_e                  fwd_rs2;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic [XLEN-1:0]       mem_fwd;

    assign retire_o = mem_wb;

    fetch_stage u_fetch (
        .clk           (clk),
        .rstn          (rstn),
        .ctrl_i        (hz_ctrl),
        .redirect_pc_i (redirect.target),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .if_id_o       (if_id)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rstn    (rstn),
        .if_id_i (if_id),
        .wb_i    (mem_wb),
        .flush_i (hz_ctrl.flush_id_ex),
        .rs1_o   (id_rs1),
        .rs2_o   (id_rs2),
        .id_ex_o (id_ex)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rstn       (rstn),
        .id_ex_i    (id_ex),
        .fwd_rs1_i  (fwd_rs1),
        .fwd_rs2_i  (fwd_rs2),
        .mem_fwd_i  (mem_fwd),
        .wb_fwd_i   (mem_wb.rd_data),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    memory_stage u_memory (
        .clk       (clk),
        .rstn      (rstn),
        .ex_mem_i  (ex_mem),
        .mem_fwd_o (mem_fwd),
        .mem_wb_o  (mem_wb)
    );

    hazard_unit u_hazard (
        .id_rs1_i   (id_rs1),
        .id_rs2_i   (id_rs2),
        .id_ex_i    (id_ex),
        .ex_mem_i   (ex_mem),
        .mem_wb_i   (mem_wb),
        .redirect_i (redirect),
        .ctrl_o     (hz_ctrl),
        .fwd_rs1_o  (fwd_rs1),
        .fwd_rs2_o  (fwd_rs2)
    );

endmodule

/* riscv_core.f */
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/riscv_core.sv
dv/riscv_core_tb.sv
